// File: design/egress_stage.sv
`timescale 1ns/1ps

module egress_stage (
  input  logic            clk,
  input  logic            reset,
  input  xbar_pkg::msg_t  in_msg,
  input  logic            in_val,
  output logic            in_rdy,
  output xbar_pkg::msg_t  send_msg,
  output logic            send_val,
  input  logic            send_rdy,
  output xbar_pkg::count_t delivered
);

  import xbar_pkg::*;

  logic full;
  msg_t data_q;
  logic load;
  logic sent;

  assign send_val = full;
  assign send_msg = data_q;

  // accept when empty or when the held word leaves this cycle
  assign in_rdy = !full || send_rdy;
  assign load = in_val && in_rdy;
  assign sent = full && send_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (load) begin
      full <= 1'b1;
    end else if (sent) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= in_msg;
    end
  end

  // wraps at the counter width
  always_ff @(posedge clk) begin
    if (reset) begin
      delivered <= '0;
    end else if (sent) begin
      delivered <= delivered + count_t'(1);
    end
  end

endmodule

// File: design/msg_fifo.sv
`timescale 1ns/1ps

module msg_fifo (
  input  logic          clk,
  input  logic          reset,
  input  xbar_pkg::msg_t in_msg,
  input  logic          in_val,
  output logic          in_rdy,
  output xbar_pkg::msg_t out_msg,
  output logic          out_val,
  input  logic          out_rdy
);

  import xbar_pkg::*;

  msg_t mem [FIFO_DEPTH];
  logic [FIFO_PTR_BITS-1:0] wr_ptr;
  logic [FIFO_PTR_BITS-1:0] rd_ptr;
  logic [FIFO_CNT_BITS-1:0] occupancy;
  logic push;
  logic pop;

  // full refuses the push even when a pop happens in the same cycle
  assign in_rdy = (occupancy != FIFO_CNT_BITS'(FIFO_DEPTH));
  assign out_val = (occupancy != '0);
  assign out_msg = mem[rd_ptr];

  assign push = in_val && in_rdy;
  assign pop = out_val && out_rdy;

  function automatic logic [FIFO_PTR_BITS-1:0] next_ptr(input logic [FIFO_PTR_BITS-1:0] ptr);
    if (ptr == FIFO_PTR_BITS'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + FIFO_PTR_BITS'(1);
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      occupancy <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // occupancy only moves when exactly one side fires
      if (push && !pop) begin
        occupancy <= occupancy + FIFO_CNT_BITS'(1);
      end else if (pop && !push) begin
        occupancy <= occupancy - FIFO_CNT_BITS'(1);
      end
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_msg;
    end
  end

endmodule

// File: design/route_crossbar.sv
`timescale 1ns/1ps

module route_crossbar (
  input  logic               clk,
  input  logic               reset,
  input  xbar_pkg::route_cfg_t cfg,
  input  logic               cfg_write,
  input  xbar_pkg::msg_t     in_msg [xbar_pkg::N_PORTS],
  input  logic               in_val [xbar_pkg::N_PORTS],
  output logic               in_rdy [xbar_pkg::N_PORTS],
  output xbar_pkg::msg_t     out_msg [xbar_pkg::N_PORTS],
  output logic               out_val [xbar_pkg::N_PORTS],
  input  logic               out_rdy [xbar_pkg::N_PORTS]
);

  import xbar_pkg::*;

  route_cfg_t stored_cfg;
  port_idx_t in_sel;
  port_idx_t out_sel;

  // local copy of the route, loaded on the csr strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      stored_cfg <= '0;
    end else if (cfg_write) begin
      stored_cfg <= cfg;
    end
  end

  // overrides pin the selector to port 0
  always_comb begin
    if (stored_cfg.input_override) begin
      in_sel = '0;
    end else begin
      in_sel = stored_cfg.route.in_sel;
    end
    if (stored_cfg.output_override) begin
      out_sel = '0;
    end else begin
      out_sel = stored_cfg.route.out_sel;
    end
  end

  // one path only, everything else idles at zero
  always_comb begin
    for (int i = 0; i < N_PORTS; i++) begin
      if (port_idx_t'(i) == out_sel) begin
        out_msg[i] = in_msg[in_sel];
        out_val[i] = in_val[in_sel];
      end else begin
        out_msg[i] = '0;
        out_val[i] = 1'b0;
      end
    end
    for (int i = 0; i < N_PORTS; i++) begin
      if (port_idx_t'(i) == in_sel) begin
        in_rdy[i] = out_rdy[out_sel];
      end else begin
        in_rdy[i] = 1'b0;
      end
    end
  end

endmodule

// File: design/xbar_csr.sv
`timescale 1ns/1ps

module xbar_csr (
  input  logic                 clk,
  input  logic                 reset,

  input  xbar_pkg::axil_addr_t awaddr,
  input  logic                 awvalid,
  output logic                 awready,
  input  xbar_pkg::axil_data_t wdata,
  input  logic                 wvalid,
  output logic                 wready,
  output xbar_pkg::axil_resp_t bresp,
  output logic                 bvalid,
  input  logic                 bready,

  input  xbar_pkg::axil_addr_t araddr,
  input  logic                 arvalid,
  output logic                 arready,
  output xbar_pkg::axil_data_t rdata,
  output xbar_pkg::axil_resp_t rresp,
  output logic                 rvalid,
  input  logic                 rready,

  input  xbar_pkg::count_t     counts [xbar_pkg::N_PORTS],
  output xbar_pkg::route_cfg_t route_cfg,
  output logic                 cfg_write
);

  import xbar_pkg::*;

  csr_state_t state;
  csr_state_t state_next;

  function automatic logic is_count_addr(input axil_addr_t addr);
    return (addr >= REG_COUNT_BASE) && (addr < REG_COUNT_END) && (addr[1:0] == 2'b00);
  endfunction

  function automatic port_idx_t count_index(input axil_addr_t addr);
    return port_idx_t'((addr - REG_COUNT_BASE) >> 2);
  endfunction

  // handshake signals straight from the state
  assign awready = (state == CSR_WADDR);
  assign wready = (state == CSR_WADDR);
  assign bvalid = (state == CSR_WRESP);
  assign arready = (state == CSR_RADDR);
  assign rvalid = (state == CSR_RDATA);

  always_comb begin
    state_next = state;
    case (state)
      CSR_IDLE: begin
        // writes win if both arrive together
        if (awvalid && wvalid) begin
          state_next = CSR_WADDR;
        end else if (arvalid) begin
          state_next = CSR_RADDR;
        end
      end
      CSR_WADDR: state_next = CSR_WRESP;
      CSR_WRESP: begin
        if (bready) begin
          state_next = CSR_IDLE;
        end
      end
      CSR_RADDR: state_next = CSR_RDATA;
      CSR_RDATA: begin
        if (rready) begin
          state_next = CSR_IDLE;
        end
      end
      default: state_next = CSR_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= CSR_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // register writes land on the aw/w handshake edge, strobe follows for one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      route_cfg <= '0;
      cfg_write <= 1'b0;
    end else begin
      cfg_write <= 1'b0;
      if (state == CSR_WADDR) begin
        if (awaddr == REG_ROUTE) begin
          route_cfg.route <= route_t'(wdata[2*PORT_BITS-1:0]);
          cfg_write <= 1'b1;
        end else if (awaddr == REG_OVERRIDE) begin
          route_cfg.input_override <= wdata[0];
          route_cfg.output_override <= wdata[1];
          cfg_write <= 1'b1;
        end
      end
    end
  end

  // write response, counters are read-only
  always_ff @(posedge clk) begin
    if (state == CSR_WADDR) begin
      if (awaddr == REG_ROUTE || awaddr == REG_OVERRIDE) begin
        bresp <= RESP_OKAY;
      end else begin
        bresp <= RESP_SLVERR;
      end
    end
  end

  // read data captured on the ar handshake
  always_ff @(posedge clk) begin
    if (state == CSR_RADDR) begin
      rresp <= RESP_OKAY;
      if (araddr == REG_ROUTE) begin
        rdata <= axil_data_t'(route_cfg.route);
      end else if (araddr == REG_OVERRIDE) begin
        rdata <= axil_data_t'({route_cfg.output_override, route_cfg.input_override});
      end else if (is_count_addr(araddr)) begin
        rdata <= axil_data_t'(counts[count_index(araddr)]);
      end else begin
        rdata <= '0;
        rresp <= RESP_SLVERR;
      end
    end
  end

endmodule

// File: design/xbar_pkg.sv
package xbar_pkg;

  // message and port geometry
  localparam int MSG_WIDTH = 32;
  localparam int N_PORTS = 4;
  localparam int PORT_BITS = 2;

  // per-input buffering
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_BITS = $clog2(FIFO_DEPTH + 1);

  localparam int COUNT_WIDTH = 16;

  // AXI4-Lite geometry
  localparam int AXIL_ADDR_WIDTH = 8;
  localparam int AXIL_DATA_WIDTH = 32;

  typedef logic [MSG_WIDTH-1:0] msg_t;
  typedef logic [PORT_BITS-1:0] port_idx_t;
  typedef logic [COUNT_WIDTH-1:0] count_t;
  typedef logic [AXIL_ADDR_WIDTH-1:0] axil_addr_t;
  typedef logic [AXIL_DATA_WIDTH-1:0] axil_data_t;

  // register map, counters are one word apart
  localparam axil_addr_t REG_ROUTE = 8'h00;
  localparam axil_addr_t REG_OVERRIDE = 8'h04;
  localparam axil_addr_t REG_COUNT_BASE = 8'h10;
  localparam axil_addr_t REG_COUNT_END = REG_COUNT_BASE + axil_addr_t'(4 * N_PORTS);

  // in_sel sits above out_sel, matching bits 3..2 and 1..0 of REG_ROUTE
  typedef struct packed {
    port_idx_t in_sel;
    port_idx_t out_sel;
  } route_t;

  typedef struct packed {
    route_t route;
    logic input_override;
    logic output_override;
  } route_cfg_t;

  typedef enum logic [1:0] {
    RESP_OKAY = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_t;

  typedef enum logic [2:0] {
    CSR_IDLE,
    CSR_WADDR,
    CSR_WRESP,
    CSR_RADDR,
    CSR_RDATA
  } csr_state_t;

endpackage

// File: design/xbar_subsystem.sv
`timescale 1ns/1ps

module xbar_subsystem (
  input  logic                 clk,
  input  logic                 reset,

  input  xbar_pkg::msg_t       recv_msg [xbar_pkg::N_PORTS],
  input  logic                 recv_val [xbar_pkg::N_PORTS],
  output logic                 recv_rdy [xbar_pkg::N_PORTS],

  output xbar_pkg::msg_t       send_msg [xbar_pkg::N_PORTS],
  output logic                 send_val [xbar_pkg::N_PORTS],
  input  logic                 send_rdy [xbar_pkg::N_PORTS],

  input  xbar_pkg::axil_addr_t awaddr,
  input  logic                 awvalid,
  output logic                 awready,
  input  xbar_pkg::axil_data_t wdata,
  input  logic                 wvalid,
  output logic                 wready,
  output xbar_pkg::axil_resp_t bresp,
  output logic                 bvalid,
  input  logic                 bready,
  input  xbar_pkg::axil_addr_t araddr,
  input  logic                 arvalid,
  output logic                 arready,
  output xbar_pkg::axil_data_t rdata,
  output xbar_pkg::axil_resp_t rresp,
  output logic                 rvalid,
  input  logic                 rready
);

  import xbar_pkg::*;

  // fifo heads into the crossbar
  msg_t fifo_msg [N_PORTS];
  logic fifo_val [N_PORTS];
  logic fifo_rdy [N_PORTS];

  // crossbar outputs into the egress slices
  msg_t egr_msg [N_PORTS];
  logic egr_val [N_PORTS];
  logic egr_rdy [N_PORTS];

  count_t counts [N_PORTS];
  route_cfg_t route_cfg;
  logic cfg_write;

  for (genvar i = 0; i < N_PORTS; i++) begin : g_port
    msg_fifo i_msg_fifo (
      .clk     (clk),
      .reset   (reset),
      .in_msg  (recv_msg[i]),
      .in_val  (recv_val[i]),
      .in_rdy  (recv_rdy[i]),
      .out_msg (fifo_msg[i]),
      .out_val (fifo_val[i]),
      .out_rdy (fifo_rdy[i])
    );

    egress_stage i_egress_stage (
      .clk       (clk),
      .reset     (reset),
      .in_msg    (egr_msg[i]),
      .in_val    (egr_val[i]),
      .in_rdy    (egr_rdy[i]),
      .send_msg  (send_msg[i]),
      .send_val  (send_val[i]),
      .send_rdy  (send_rdy[i]),
      .delivered (counts[i])
    );
  end

  route_crossbar i_route_crossbar (
    .clk       (clk),
    .reset     (reset),
    .cfg       (route_cfg),
    .cfg_write (cfg_write),
    .in_msg    (fifo_msg),
    .in_val    (fifo_val),
    .in_rdy    (fifo_rdy),
    .out_msg   (egr_msg),
    .out_val   (egr_val),
    .out_rdy   (egr_rdy)
  );

  xbar_csr i_xbar_csr (
    .clk       (clk),
    .reset     (reset),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .counts    (counts),
    .route_cfg (route_cfg),
    .cfg_write (cfg_write)
  );

endmodule

// File: tb/xbar_checker.sv
`timescale 1ns/1ps

module xbar_checker (
  input  logic                 clk,
  input  logic                 reset,
  input  xbar_pkg::msg_t       recv_msg [xbar_pkg::N_PORTS],
  input  logic                 recv_val [xbar_pkg::N_PORTS],
  input  logic                 recv_rdy [xbar_pkg::N_PORTS],
  input  xbar_pkg::msg_t       send_msg [xbar_pkg::N_PORTS],
  input  logic                 send_val [xbar_pkg::N_PORTS],
  input  logic                 send_rdy [xbar_pkg::N_PORTS],
  input  xbar_pkg::axil_addr_t awaddr,
  input  logic                 awvalid,
  input  logic                 awready,
  input  xbar_pkg::axil_data_t wdata,
  input  logic                 wvalid,
  input  logic                 wready,
  input  xbar_pkg::axil_resp_t bresp,
  input  logic                 bvalid,
  input  logic                 bready,
  input  xbar_pkg::axil_addr_t araddr,
  input  logic                 arvalid,
  input  logic                 arready,
  input  xbar_pkg::axil_data_t rdata,
  input  xbar_pkg::axil_resp_t rresp,
  input  logic                 rvalid,
  input  logic                 rready,
  output int                   errors,
  output int                   outstanding
);

  import xbar_pkg::*;

  localparam int Q_DEPTH = 64;

  // expected messages per input, in arrival order
  msg_t exp_mem [N_PORTS][Q_DEPTH];
  int head [N_PORTS];
  int tail [N_PORTS];
  count_t sent [N_PORTS];
  logic [3:0] route_reg;
  logic [1:0] ovr_reg;
  port_idx_t eff_in;
  port_idx_t eff_out;
  axil_resp_t exp_bresp;
  axil_resp_t exp_rresp;
  axil_data_t exp_rdata;
  axil_addr_t rd_addr;
  int in_fifo;

  // an override pins its side of the path to port 0
  assign eff_in = ovr_reg[0] ? port_idx_t'(0) : route_reg[3:2];
  assign eff_out = ovr_reg[1] ? port_idx_t'(0) : route_reg[1:0];

  task automatic fail_check(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    errors++;
  endtask

  always @(posedge clk) begin
    if (reset) begin
      route_reg = '0;
      ovr_reg = '0;
      outstanding = 0;
      foreach (sent[i]) begin
        sent[i] = '0;
        head[i] = 0;
        tail[i] = 0;
      end
    end else begin
      // register model follows each accepted write
      if (awvalid && awready && wvalid && wready) begin
        if (awaddr == REG_ROUTE) begin
          route_reg = wdata[3:0];
          exp_bresp = RESP_OKAY;
        end else if (awaddr == REG_OVERRIDE) begin
          ovr_reg = wdata[1:0];
          exp_bresp = RESP_OKAY;
        end else begin
          exp_bresp = RESP_SLVERR;
        end
      end
      if (bvalid && bready && bresp !== exp_bresp) begin
        fail_check($sformatf("bresp %0d, expected %0d", bresp, exp_bresp));
      end
      // read value is fixed at the address handshake
      if (arvalid && arready) begin
        rd_addr = araddr;
        exp_rresp = RESP_OKAY;
        exp_rdata = '0;
        if (araddr == REG_ROUTE) begin
          exp_rdata = axil_data_t'(route_reg);
        end else if (araddr == REG_OVERRIDE) begin
          exp_rdata = axil_data_t'(ovr_reg);
        end else if (araddr >= REG_COUNT_BASE && araddr < REG_COUNT_BASE + 8'(4 * N_PORTS)
                     && araddr[1:0] == 2'b00) begin
          exp_rdata = axil_data_t'(sent[(araddr - REG_COUNT_BASE) >> 2]);
        end else begin
          exp_rresp = RESP_SLVERR;
        end
      end
      if (rvalid && rready) begin
        if (rresp !== exp_rresp) begin
          fail_check($sformatf("rresp %0d at %h, expected %0d", rresp, rd_addr, exp_rresp));
        end else if (rresp == RESP_OKAY && rdata !== exp_rdata) begin
          fail_check($sformatf("read of %h gave %h, expected %h", rd_addr, rdata, exp_rdata));
        end
      end
      for (int i = 0; i < N_PORTS; i++) begin
        // the egress slice of the open path holds one message outside the fifo
        in_fifo = tail[i] - head[i];
        if (port_idx_t'(i) == eff_in && send_val[eff_out]) begin
          in_fifo--;
        end
        if (!recv_rdy[i] && in_fifo < FIFO_DEPTH) begin
          fail_check($sformatf("recv_rdy low on input %0d with %0d in its fifo",
                               i, in_fifo));
        end
        if (recv_val[i] && recv_rdy[i]) begin
          exp_mem[i][tail[i] % Q_DEPTH] = recv_msg[i];
          tail[i]++;
          outstanding++;
        end
      end
      for (int o = 0; o < N_PORTS; o++) begin
        if (send_val[o] && port_idx_t'(o) != eff_out) begin
          fail_check($sformatf("send_val high on unrouted output %0d", o));
        end else if (send_val[o] && send_rdy[o]) begin
          if (head[eff_in] == tail[eff_in]) begin
            fail_check($sformatf("unexpected message %h on output %0d", send_msg[o], o));
          end else begin
            if (send_msg[o] !== exp_mem[eff_in][head[eff_in] % Q_DEPTH]) begin
              fail_check($sformatf("output %0d sent %h, expected %h", o, send_msg[o],
                                   exp_mem[eff_in][head[eff_in] % Q_DEPTH]));
            end
            head[eff_in]++;
            outstanding--;
          end
        end
        if (send_val[o] && send_rdy[o]) begin
          sent[o] = sent[o] + count_t'(1);
        end
      end
    end
  end

endmodule

// File: tb/xbar_tb.sv
`timescale 1ns/1ps

module xbar_tb;

  import xbar_pkg::*;

  typedef struct packed {
    port_idx_t port;
    port_idx_t in_sel;
    port_idx_t out_sel;
    logic in_ovr;
    logic out_ovr;
    logic [7:0] count;
    msg_t base;
    logic stall;
  } entry_t;

  localparam int N_ENTRIES = 8;
  localparam int TIMEOUT_CYCLES = N_ENTRIES * 200 + 100;

  // port, in_sel, out_sel, input override, output override, count, base, stall
  entry_t stim [N_ENTRIES] = '{
    '{2'd0, 2'd0, 2'd1, 1'b0, 1'b0, 8'd3, 32'h1000_0000, 1'b0},
    '{2'd2, 2'd2, 2'd3, 1'b0, 1'b0, 8'd4, 32'h2000_0000, 1'b0},
    '{2'd0, 2'd2, 2'd3, 1'b1, 1'b0, 8'd3, 32'h3000_0000, 1'b0},
    '{2'd1, 2'd1, 2'd2, 1'b0, 1'b1, 8'd3, 32'h4000_0000, 1'b0},
    '{2'd0, 2'd3, 2'd2, 1'b1, 1'b1, 8'd2, 32'h5000_0000, 1'b0},
    // input 3 is not routed here, its messages wait in the fifo
    '{2'd3, 2'd3, 2'd1, 1'b1, 1'b0, 8'd2, 32'h6000_0000, 1'b0},
    '{2'd3, 2'd3, 2'd2, 1'b0, 1'b0, 8'd10, 32'h7000_0000, 1'b1},
    '{2'd1, 2'd1, 2'd3, 1'b0, 1'b0, 8'd6, 32'h8000_0000, 1'b1}
  };

  logic clk;
  logic reset;
  msg_t recv_msg [N_PORTS];
  logic recv_val [N_PORTS];
  logic recv_rdy [N_PORTS];
  msg_t send_msg [N_PORTS];
  logic send_val [N_PORTS];
  logic send_rdy [N_PORTS];
  axil_addr_t awaddr;
  logic awvalid;
  logic awready;
  axil_data_t wdata;
  logic wvalid;
  logic wready;
  axil_resp_t bresp;
  logic bvalid;
  logic bready;
  axil_addr_t araddr;
  logic arvalid;
  logic arready;
  axil_data_t rdata;
  axil_resp_t rresp;
  logic rvalid;
  logic rready;
  int check_errors;
  int outstanding;
  int tb_errors = 0;
  int cycles = 0;

  xbar_subsystem i_xbar_subsystem (.*);

  xbar_checker i_xbar_checker (.errors(check_errors), .*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("errors: checker %0d, testbench %0d", check_errors, tb_errors + 1);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic axi_write(input axil_addr_t addr, input axil_data_t data);
    @(negedge clk);
    awaddr = addr;
    wdata = data;
    awvalid = 1'b1;
    wvalid = 1'b1;
    bready = 1'b1;
    while (!awready) @(negedge clk);
    @(negedge clk);
    awvalid = 1'b0;
    wvalid = 1'b0;
    while (!bvalid) @(negedge clk);
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input axil_addr_t addr);
    @(negedge clk);
    araddr = addr;
    arvalid = 1'b1;
    rready = 1'b1;
    while (!arready) @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk);
    @(negedge clk);
    rready = 1'b0;
  endtask

  // one message per cycle while the fifo has room
  task automatic push_msgs(input port_idx_t port, input int count, input msg_t base);
    for (int k = 0; k < count; k++) begin
      recv_msg[port] = base + msg_t'(k);
      recv_val[port] = 1'b1;
      while (!recv_rdy[port]) @(negedge clk);
      @(negedge clk);
    end
    recv_val[port] = 1'b0;
    recv_msg[port] = '0;
  endtask

  task automatic set_send_rdy(input logic value);
    foreach (send_rdy[i]) begin
      send_rdy[i] = value;
    end
  endtask

  task automatic stall_outputs();
    int span;
    for (int s = 0; s < 6; s++) begin
      span = ($urandom % 8) + 1;
      set_send_rdy(1'b0);
      repeat (span) @(negedge clk);
      span = ($urandom % 3) + 1;
      set_send_rdy(1'b1);
      repeat (span) @(negedge clk);
    end
  endtask

  task automatic wait_idle();
    int idle;
    logic busy;
    idle = 0;
    while (idle < 8) begin
      @(negedge clk);
      busy = 1'b0;
      foreach (send_val[i]) begin
        busy = busy | send_val[i];
      end
      if (busy) begin
        idle = 0;
      end else begin
        idle++;
      end
    end
  endtask

  initial begin
    void'($urandom(58780));
    reset = 1'b1;
    foreach (recv_msg[i]) begin
      recv_msg[i] = '0;
      recv_val[i] = 1'b0;
      send_rdy[i] = 1'b1;
    end
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    // state straight out of reset
    axi_read(REG_ROUTE);
    for (int i = 0; i < N_PORTS; i++) begin
      axi_read(REG_COUNT_BASE + axil_addr_t'(4 * i));
    end

    // route goes first so no stale path opens between the two writes
    foreach (stim[e]) begin
      axi_write(REG_ROUTE, {28'd0, stim[e].in_sel, stim[e].out_sel});
      axi_write(REG_OVERRIDE, {30'd0, stim[e].out_ovr, stim[e].in_ovr});
      if (stim[e].stall) begin
        fork
          push_msgs(stim[e].port, int'(stim[e].count), stim[e].base);
          stall_outputs();
        join
      end else begin
        push_msgs(stim[e].port, int'(stim[e].count), stim[e].base);
      end
      wait_idle();
    end

    // readback, then refused writes must leave the registers alone
    axi_read(REG_ROUTE);
    axi_read(REG_OVERRIDE);
    axi_write(8'h08, 32'hffff_ffff);
    axi_write(REG_COUNT_BASE + 8'h04, 32'h0000_1234);
    axi_read(REG_ROUTE);
    axi_read(REG_OVERRIDE);
    axi_read(8'h08);
    for (int i = 0; i < N_PORTS; i++) begin
      axi_read(REG_COUNT_BASE + axil_addr_t'(4 * i));
    end

    if (outstanding != 0) begin
      $display("%0d messages were accepted but never delivered", outstanding);
      tb_errors++;
    end
    $display("errors: checker %0d, testbench %0d", check_errors, tb_errors);
    if (check_errors + tb_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: xbar_subsystem.f
design/xbar_pkg.sv
design/msg_fifo.sv
design/route_crossbar.sv
design/egress_stage.sv
design/xbar_csr.sv
design/xbar_subsystem.sv
tb/xbar_checker.sv
tb/xbar_tb.sv
